// File: design/arrayHeap.sv
`timescale 1ns/1ps
//--------------------
// Array heap
// Three stage pipeline over a fixed set of arrays
//--------------------
module arrayHeap #(
  parameter int addressBits = heapPkg::defaultAddressBits,
  parameter int indexBits   = heapPkg::defaultIndexBits,
  parameter int dataBits    = heapPkg::defaultDataBits
) (
  input  logic                   clock,
  input  logic                   resetN,
  input  logic                   start,         // One command per cycle
  input  heapPkg::heapOp         op,
  input  logic [addressBits-1:0] array,
  input  logic [indexBits-1:0]   index,
  input  logic [dataBits-1:0]    dataIn,
  output logic                   done,          // Three cycles after start
  output logic [dataBits-1:0]    dataOut,
  output heapPkg::heapErr        error
);

  //--------------------
  // Stage links
  //--------------------
  heapStageIf #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits))
    cmdToAccess ();
  heapStageIf #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits))
    accessToWriteback ();
  heapStageIf #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits))
    writeBack ();                               // Element updates back to stage 2

  //--------------------
  // Stages
  //--------------------
  heapCommandStage #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits))
    commandStage0 (
      .clock    (clock),
      .resetN   (resetN),
      .start    (start),
      .op       (op),
      .array    (array),
      .index    (index),
      .dataIn   (dataIn),
      .toAccess (cmdToAccess.source)
    );

  heapAccessStage #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits))
    accessStage0 (
      .clock       (clock),
      .resetN      (resetN),
      .fromCommand (cmdToAccess.sink),
      .writeBack   (writeBack.sink),
      .toWriteback (accessToWriteback.source)
    );

  heapWritebackStage #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits))
    writebackStage0 (
      .clock      (clock),
      .resetN     (resetN),
      .fromAccess (accessToWriteback.sink),
      .writeBack  (writeBack.source),
      .done       (done),
      .dataOut    (dataOut),
      .error      (error)
    );

endmodule

// File: design/heapAccessStage.sv
`timescale 1ns/1ps
//--------------------
// Heap access stage
// Element memory with one write port and a forwarded read
//--------------------
module heapAccessStage #(
  parameter int addressBits = 2,
  parameter int indexBits   = 3,
  parameter int dataBits    = 12
) (
  input logic        clock,
  input logic        resetN,
  heapStageIf.sink   fromCommand,
  heapStageIf.sink   writeBack,                 // Updates from stage 3
  heapStageIf.source toWriteback
);
  localparam int arrays      = 2 ** addressBits;
  localparam int arrayLength = 2 ** indexBits;

  logic [dataBits-1:0] elements [arrays][arrayLength];  // All arrays side by side

  logic [dataBits-1:0] stored;                  // Memory contents
  logic                hit;                     // Write back to same element
  logic [dataBits-1:0] element;                 // Value after forwarding

  //--------------------
  // Write port
  //--------------------
  always_ff @(posedge clock) begin
    if (writeBack.valid) begin
      elements[writeBack.array][writeBack.index] <= writeBack.data;
    end
  end

  //--------------------
  // Read with forwarding
  //--------------------
  assign stored  = elements[fromCommand.array][fromCommand.index];
  assign hit     = writeBack.valid &&
                   writeBack.array == fromCommand.array &&
                   writeBack.index == fromCommand.index;
  assign element = hit ? writeBack.data : stored;      // Newest value wins

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      toWriteback.valid <= 1'b0;
    end else begin
      toWriteback.valid <= fromCommand.valid;
    end
  end

  // Command, element and operand onward
  always_ff @(posedge clock) begin
    toWriteback.op    <= fromCommand.op;
    toWriteback.array <= fromCommand.array;
    toWriteback.index <= fromCommand.index;
    toWriteback.error <= fromCommand.error;
    toWriteback.data  <= element;
    if (fromCommand.op == heapPkg::opSize) begin
      toWriteback.size <= fromCommand.size;     // Size is the answer here
    end else begin
      toWriteback.size <= fromCommand.data;     // Original dataIn
    end
  end

endmodule

// File: design/heapCommandStage.sv
`timescale 1ns/1ps
//--------------------
// Heap command stage
// Handle allocation, array sizes and all command checks
//--------------------
module heapCommandStage #(
  parameter int addressBits = 2,
  parameter int indexBits   = 3,
  parameter int dataBits    = 12
) (
  input  logic                   clock,
  input  logic                   resetN,
  input  logic                   start,         // Command strobe
  input  heapPkg::heapOp         op,
  input  logic [addressBits-1:0] array,
  input  logic [indexBits-1:0]   index,
  input  logic [dataBits-1:0]    dataIn,
  heapStageIf.source             toAccess
);
  localparam int arrays = 2 ** addressBits;

  logic [arrays-1:0]      allocated;            // Handle in use
  logic [indexBits:0]     sizes [arrays];       // Elements per array
  logic [addressBits-1:0] freeStack [arrays];   // Freed handles, last on top
  logic [addressBits:0]   freeTop;              // Free stack depth
  logic [addressBits:0]   nextHandle;           // Next never used handle

  logic [indexBits:0]     curSize;
  logic [indexBits:0]     sizeLess;
  logic [addressBits:0]   freeTopLess;
  logic [addressBits-1:0] chosen;               // Handle sent onward
  logic [indexBits-1:0]   effIndex;             // Index sent onward
  heapPkg::heapErr        err;
  logic                   good;

  assign curSize     = sizes[array];
  assign sizeLess    = curSize - 1'b1;          // New size after pop
  assign freeTopLess = freeTop - 1'b1;
  assign good        = start && err == heapPkg::errNone;

  //--------------------
  // Checks
  //--------------------
  always_comb begin
    err      = heapPkg::errNone;
    chosen   = array;
    effIndex = index;
    if (op == heapPkg::opAlloc) begin
      if (freeTop != '0) begin
        chosen = freeStack[freeTopLess[addressBits-1:0]];   // Reuse last freed
      end else if (!nextHandle[addressBits]) begin
        chosen = nextHandle[addressBits-1:0];               // Fresh handle
      end else begin
        err = heapPkg::errOutOfMemory;
      end
    end else if (op != heapPkg::opClear) begin
      if (!allocated[array]) begin
        err = heapPkg::errNotAllocated;
      end else begin
        case (op)
          heapPkg::opRead, heapPkg::opAdd: begin
            if ({1'b0, index} >= curSize) err = heapPkg::errOutOfBounds;
          end
          heapPkg::opPush: begin
            effIndex = curSize[indexBits-1:0];              // Slot past the end
            if (curSize[indexBits]) err = heapPkg::errFull; // All slots used
          end
          heapPkg::opPop: begin
            effIndex = sizeLess[indexBits-1:0];             // Last element
            if (curSize == '0) err = heapPkg::errEmpty;
          end
          default: begin
          end
        endcase
      end
    end
  end

  //--------------------
  // Allocation state
  //--------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated      <= '0;
      freeTop        <= '0;
      nextHandle     <= '0;
      toAccess.valid <= 1'b0;
    end else begin
      toAccess.valid <= start;
      if (good) begin
        case (op)
          heapPkg::opClear: begin
            allocated  <= '0;
            freeTop    <= '0;
            nextHandle <= '0;
          end
          heapPkg::opAlloc: begin
            allocated[chosen] <= 1'b1;
            if (freeTop != '0) freeTop <= freeTopLess;      // Pop free stack
            else nextHandle <= nextHandle + 1'b1;
          end
          heapPkg::opFree: begin
            allocated[array] <= 1'b0;
            freeTop          <= freeTop + 1'b1;
          end
          default: begin
          end
        endcase
      end
    end
  end

  // Sizes, free stack and forwarded command
  always_ff @(posedge clock) begin
    if (good) begin
      case (op)
        heapPkg::opAlloc: sizes[chosen] <= '0;              // New array is empty
        heapPkg::opFree:  freeStack[freeTop[addressBits-1:0]] <= array;
        heapPkg::opWrite: begin
          if ({1'b0, index} >= curSize) sizes[array] <= {1'b0, index} + 1'b1;
        end
        heapPkg::opPush:  sizes[array] <= curSize + 1'b1;
        heapPkg::opPop:   sizes[array] <= sizeLess;
        default: begin
        end
      endcase
    end
    toAccess.op    <= op;
    toAccess.array <= chosen;
    toAccess.index <= effIndex;
    toAccess.data  <= dataIn;
    toAccess.error <= err;
    toAccess.size  <= dataBits'(curSize);           // Size before this command
  end

endmodule

// File: design/heapPkg.sv
//--------------------
// Array heap package
// Command and error encodings plus the default heap geometry
//--------------------
package heapPkg;

  //--------------------
  // Commands
  //--------------------
  typedef enum logic [3:0] {
    opClear = 4'd0,                             // Empty the whole heap
    opAlloc = 4'd1,                             // New array handle
    opFree  = 4'd2,                             // Release a handle
    opWrite = 4'd3,                             // Write element, may grow array
    opRead  = 4'd4,                             // Read element
    opSize  = 4'd5,                             // Current array size
    opPush  = 4'd6,                             // Append at the end
    opPop   = 4'd7,                             // Remove from the end
    opAdd   = 4'd8                              // Add to element, new value out
  } heapOp;

  //--------------------
  // Errors
  //--------------------
  typedef enum logic [2:0] {
    errNone         = 3'd0,                     // Command went through
    errNotAllocated = 3'd1,                     // Handle not in use
    errOutOfBounds  = 3'd2,                     // Index at or past size
    errFull         = 3'd3,                     // Push to full array
    errEmpty        = 3'd4,                     // Pop of empty array
    errOutOfMemory  = 3'd5                      // No handle left
  } heapErr;

  //--------------------
  // Default geometry
  //--------------------
  // Four arrays of eight twelve bit elements
  parameter int defaultAddressBits = 2;         // Handle width
  parameter int defaultIndexBits   = 3;         // Element index width
  parameter int defaultDataBits    = 12;        // Element width

endpackage

// File: design/heapStageIf.sv
`timescale 1ns/1ps
//--------------------
// Heap stage link
// One command moving between two pipeline stages
//--------------------
interface heapStageIf #(
  parameter int addressBits = 2,
  parameter int indexBits   = 3,
  parameter int dataBits    = 12
);
  logic                   valid;                // Command present
  heapPkg::heapOp         op;                   // Command code
  logic [addressBits-1:0] array;                // Handle
  logic [indexBits-1:0]   index;                // Element index
  logic [dataBits-1:0]    data;                 // Data word
  heapPkg::heapErr        error;                // Error found so far
  logic [dataBits-1:0]    size;                 // Size or original data

  modport source (
    output valid, op, array, index, data, error, size
  );

  modport sink (
    input valid, op, array, index, data, error, size
  );

endinterface

// File: design/heapWritebackStage.sv
`timescale 1ns/1ps
//--------------------
// Heap write back stage
// Result word, element updates and the registered outputs
//--------------------
module heapWritebackStage #(
  parameter int addressBits = 2,
  parameter int indexBits   = 3,
  parameter int dataBits    = 12
) (
  input  logic                clock,
  input  logic                resetN,
  heapStageIf.sink            fromAccess,
  heapStageIf.source          writeBack,
  output logic                done,
  output logic [dataBits-1:0] dataOut,
  output heapPkg::heapErr     error
);
  logic [dataBits-1:0] result;
  logic                good;                    // Valid and no error
  logic                updates;                 // Command writes an element

  assign good = fromAccess.valid && fromAccess.error == heapPkg::errNone;

  //--------------------
  // Result
  //--------------------
  always_comb begin
    result  = '0;                               // Clear and free
    updates = 1'b0;
    case (fromAccess.op)
      heapPkg::opWrite, heapPkg::opPush: begin
        result  = fromAccess.size;              // dataIn
        updates = 1'b1;
      end
      heapPkg::opRead, heapPkg::opPop: result = fromAccess.data;
      heapPkg::opAdd: begin
        result  = fromAccess.data + fromAccess.size;        // Wraps at dataBits
        updates = 1'b1;
      end
      heapPkg::opSize:  result = fromAccess.size;
      heapPkg::opAlloc: result = dataBits'(fromAccess.array);
      default: begin
      end
    endcase
  end

  // Element update, written on the output edge
  assign writeBack.valid = good && updates;
  assign writeBack.op    = fromAccess.op;
  assign writeBack.array = fromAccess.array;
  assign writeBack.index = fromAccess.index;
  assign writeBack.data  = result;
  assign writeBack.error = heapPkg::errNone;
  assign writeBack.size  = '0;

  //--------------------
  // Outputs
  //--------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      done    <= 1'b0;
      dataOut <= '0;
      error   <= heapPkg::errNone;
    end else begin
      done    <= fromAccess.valid;
      dataOut <= good ? result : '0;            // Zero on error
      error   <= fromAccess.valid ? fromAccess.error : heapPkg::errNone;
    end
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Compile the array heap testbench with Verilator and run it.
# The exit status is the simulator's own.
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing -f src.f --top-module arrayHeapTb \
  -Mdir obj_dir -o arrayHeapSim \
  && ./obj_dir/arrayHeapSim \
  || exit 1

// File: src.f
design/heapPkg.sv
design/heapStageIf.sv
design/heapCommandStage.sv
design/heapAccessStage.sv
design/heapWritebackStage.sv
design/arrayHeap.sv
tb/tbClockGen.sv
tb/arrayHeapAssertions.sv
tb/arrayHeapTb.sv

// File: tb/arrayHeapAssertions.sv
`timescale 1ns/1ps
//--------------------
// Array heap output checks
// Bound to the top level, watches done timing and the error code
//--------------------
module arrayHeapAssertions (
  input logic            clock,
  input logic            resetN,
  input logic            start,
  input logic            done,
  input heapPkg::heapErr error
);
  // No result while in reset
  doneInReset: assert property (@(posedge clock) !resetN |-> !done)
    else $error("done high while reset is active");

  // Every command answers three edges later
  doneAfterStart: assert property (@(posedge clock) disable iff (!resetN)
    $past(start, 3) |-> done)
    else $error("command not answered after three cycles");

  doneNeedsStart: assert property (@(posedge clock) disable iff (!resetN)
    done |-> $past(start, 3))
    else $error("done without a command three cycles before");

  // Idle output carries no error
  quietError: assert property (@(posedge clock) disable iff (!resetN)
    !done |-> error == heapPkg::errNone)
    else $error("error code set while done is low");

endmodule

bind arrayHeap arrayHeapAssertions assertions0 (
  .clock  (clock),
  .resetN (resetN),
  .start  (start),
  .done   (done),
  .error  (error)
);

// File: tb/arrayHeapTb.sv
`timescale 1ns/1ps
//--------------------
// Array heap testbench
// Directed command sequences, results checked in a monitor
//--------------------
module arrayHeapTb;
  localparam int addressBits  = heapPkg::defaultAddressBits;
  localparam int indexBits    = heapPkg::defaultIndexBits;
  localparam int dataBits     = heapPkg::defaultDataBits;
  localparam int arrays       = 1 << addressBits;
  localparam int clockPeriod  = 8;
  localparam int resetCycles  = 16;
  localparam int addCount     = 6;              // Back to back adds
  localparam int commandCount = 34;             // All commands in all tests

  logic                   clock;
  logic                   resetN;
  logic                   start;
  heapPkg::heapOp         op;
  logic [addressBits-1:0] array;
  logic [indexBits-1:0]   index;
  logic [dataBits-1:0]    dataIn;
  logic                   done;
  logic [dataBits-1:0]    dataOut;
  heapPkg::heapErr        error;

  logic [dataBits-1:0]    expData [$];          // Expected results in order
  heapPkg::heapErr        expErr [$];
  logic [2:0]             startHist;            // start seen on past edges

  tbClockGen #(.periodNs(clockPeriod), .resetCycles(resetCycles)) clockGen0 (
    .clock  (clock),
    .resetN (resetN)
  );

  arrayHeap #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits)) dut0 (
    .clock   (clock),
    .resetN  (resetN),
    .start   (start),
    .op      (op),
    .array   (array),
    .index   (index),
    .dataIn  (dataIn),
    .done    (done),
    .dataOut (dataOut),
    .error   (error)
  );

  //--------------------
  // Helpers
  //--------------------
  task automatic checkValue(input string what, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
      $display("Simulation FAILED");
      $fatal(1, "Result mismatch");
    end
  endtask

  function automatic int wrapData(input int value);
    return value & ((1 << dataBits) - 1);       // Modulo element width
  endfunction

  // One command per call with its expected result
  task automatic sendCommand(input heapPkg::heapOp cmd, input int handle, input int idx,
                             input int value, input int result, input heapPkg::heapErr err);
    @(posedge clock);
    start  <= 1'b1;
    op     <= cmd;
    array  <= addressBits'(handle);
    index  <= indexBits'(idx);
    dataIn <= dataBits'(value);
    expData.push_back(dataBits'(result));
    expErr.push_back(err);
  endtask

  // Stop issuing and wait for every answer
  task automatic endBurst();
    @(posedge clock);
    start <= 1'b0;
    while (expData.size() != 0) @(posedge clock);
  endtask

  // Monitor checks done timing against start, then result and error
  always @(posedge clock) begin
    if (!resetN) begin
      startHist <= '0;
    end else begin
      checkValue("done", 32'(done), 32'(startHist[2]));
      if (done && expData.size() == 0) begin
        $display("done arrived at %0t ns with no command outstanding", $time);
        $display("Simulation FAILED");
        $fatal(1, "Unexpected done");
      end else begin
        if (done) begin
          checkValue("dataOut", 32'(dataOut), 32'(expData.pop_front()));
          checkValue("error", 32'(error), 32'(expErr.pop_front()));
        end
        startHist <= {startHist[1:0], start};
      end
    end
  end

  //--------------------
  // Tests
  //--------------------
  task automatic testAllocation();
    sendCommand(heapPkg::opClear, 0, 0, 0, 0, heapPkg::errNone);
    for (int h = 0; h < arrays; h++) begin
      sendCommand(heapPkg::opAlloc, 0, 0, 0, h, heapPkg::errNone);   // Fresh handles in order
    end
    sendCommand(heapPkg::opAlloc, 0, 0, 0, 0, heapPkg::errOutOfMemory);
    endBurst();
  endtask

  task automatic testPushPop();
    int a;
    int b;
    a = wrapData(int'($urandom));
    b = wrapData(int'($urandom));
    sendCommand(heapPkg::opPush, 0, 0, a, a, heapPkg::errNone);
    sendCommand(heapPkg::opPush, 0, 0, b, b, heapPkg::errNone);
    sendCommand(heapPkg::opSize, 0, 0, 0, 2, heapPkg::errNone);
    sendCommand(heapPkg::opRead, 0, 0, 0, a, heapPkg::errNone);
    sendCommand(heapPkg::opRead, 0, 1, 0, b, heapPkg::errNone);
    sendCommand(heapPkg::opPop, 0, 0, 0, b, heapPkg::errNone);      // Last in first out
    sendCommand(heapPkg::opPop, 0, 0, 0, a, heapPkg::errNone);
    sendCommand(heapPkg::opPop, 0, 0, 0, 0, heapPkg::errEmpty);
    endBurst();
  endtask

  task automatic testGrowAndFull();
    int c;
    c = wrapData(int'($urandom));
    sendCommand(heapPkg::opWrite, 1, 5, c, c, heapPkg::errNone);    // Grows size to 6
    sendCommand(heapPkg::opSize, 1, 0, 0, 6, heapPkg::errNone);
    sendCommand(heapPkg::opRead, 1, 6, 0, 0, heapPkg::errOutOfBounds);
    sendCommand(heapPkg::opPush, 1, 0, c ^ 1, c ^ 1, heapPkg::errNone);
    sendCommand(heapPkg::opPush, 1, 0, c ^ 2, c ^ 2, heapPkg::errNone);  // Size now 8
    sendCommand(heapPkg::opPush, 1, 0, c, 0, heapPkg::errFull);
    endBurst();
  endtask

  task automatic testForwarding();
    int sum;
    int operand;
    sum = wrapData(int'($urandom));
    sendCommand(heapPkg::opWrite, 3, 2, sum, sum, heapPkg::errNone);
    for (int i = 0; i < addCount; i++) begin
      operand = wrapData(int'($urandom));
      sum     = wrapData(sum + operand);        // Running sum wraps
      sendCommand(heapPkg::opAdd, 3, 2, operand, sum, heapPkg::errNone);
    end
    endBurst();
  endtask

  task automatic testFreeReuse();
    int d;
    d = wrapData(int'($urandom));
    sendCommand(heapPkg::opPush, 2, 0, d, d, heapPkg::errNone);     // Size 1 before free
    sendCommand(heapPkg::opFree, 2, 0, 0, 0, heapPkg::errNone);
    sendCommand(heapPkg::opRead, 2, 0, 0, 0, heapPkg::errNotAllocated);
    sendCommand(heapPkg::opSize, 2, 0, 0, 0, heapPkg::errNotAllocated);
    sendCommand(heapPkg::opPush, 2, 0, 7, 0, heapPkg::errNotAllocated);
    sendCommand(heapPkg::opAlloc, 0, 0, 0, 2, heapPkg::errNone);    // Freed handle back
    sendCommand(heapPkg::opSize, 2, 0, 0, 0, heapPkg::errNone);
    endBurst();
  endtask

  //--------------------
  // Run
  //--------------------
  initial begin
    void'($urandom(40393));
    start  = 1'b0;
    op     = heapPkg::opClear;
    array  = '0;
    index  = '0;
    dataIn = '0;
    @(posedge resetN);
    testAllocation();
    testPushPop();
    testGrowAndFull();
    testForwarding();
    testFreeReuse();
    $display("Simulation PASSED");
    $finish;
  end

  // Watchdog allows eight cycles per command plus reset
  initial begin
    #(commandCount * 8 * clockPeriod + resetCycles * clockPeriod);
    $display("Timeout: the tests did not finish in time");
    $display("Simulation FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule

// File: tb/tbClockGen.sv
`timescale 1ns/1ps
//--------------------
// Testbench clock and reset
//--------------------
module tbClockGen #(
  parameter int periodNs    = 8,
  parameter int resetCycles = 16
) (
  output logic clock,
  output logic resetN
);
  initial begin
    clock = 1'b0;
    forever #(periodNs / 2) clock = ~clock;     // Free running
  end

  initial begin
    resetN = 1'b0;                              // Held from time zero
    repeat (resetCycles) @(posedge clock);
    resetN <= 1'b1;                             // Released on an edge
  end

endmodule
